// ==== kiwi_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// shared constants for the eCPU control and status block
// op members are bit positions in the op word, one bit per function
// FPGA_VER and FPGA_ID are fixed and reported in the status word
//////////////////////////////////////////////////////////////////////

package kiwi_pkg;

    // bus widths
    localparam int OP_W  = 16;
    localparam int TOS_W = 32;
    localparam int PAR_W = 16;
    localparam int CTR_W = 32;

    // 2-bit read sub-select, op[7:6]
    localparam int REG_NO_LSB = 6;

    // op word bit positions
    // several may be set at once by the CPU, each block checks its own
    typedef enum logic [3:0] {
        OP_SET_CTRL    = 4'd8,
        OP_GET_STATUS  = 4'd9,
        OP_GET_CPU_CTR = 4'd10,
        OP_GET_ADC_CTR = 4'd11,
        OP_GET_SRQ     = 4'd12,
        OP_CPU_CTR_CLR = 4'd13,
        OP_CPU_CTR_ENA = 4'd14,
        OP_CPU_CTR_DIS = 4'd15
    } op_bit_e;

    //////////////////////////////////////////////////////////////////
    // control register layout
    //////////////////////////////////////////////////////////////////

    // serial select field, 2 bits
    localparam int CTRL_SER_LSB    = 0;
    // bit-banged serial lines, shared by both ports
    localparam int CTRL_SER_LE_CSN = 2;
    localparam int CTRL_SER_CLK    = 3;
    localparam int CTRL_SER_DATA   = 4;
    // fixed control outputs
    localparam int CTRL_STEN       = 5;
    localparam int CTRL_OSC_DIS    = 6;
    localparam int CTRL_EEPROM_WP  = 7;
    localparam int CTRL_CMD_READY  = 8;
    localparam int CTRL_SND_INTR   = 9;

    // serial select codes, code 3 is unused and parks both ports
    localparam logic [1:0] SER_NONE = 2'd0;
    localparam logic [1:0] SER_ATTN = 2'd1;
    localparam logic [1:0] SER_GPS  = 2'd2;

    // status word constants
    localparam logic [3:0] FPGA_VER = 4'd3;
    localparam logic [3:0] FPGA_ID  = 4'd1;

endpackage

// ==== cpu_bus_if.sv ====
//////////////////////////////////////////////////////////////////////
// eCPU register bus, single-cycle strobes with no handshake
// op and tos are only meaningful while a strobe is high
//////////////////////////////////////////////////////////////////////

interface cpu_bus_if import kiwi_pkg::*; ();

    // current instruction op word and top of stack
    logic [OP_W-1:0]  op;
    logic [TOS_W-1:0] tos;

    // strobes, one cycle each
    logic rd_reg;
    // register write
    logic wr_reg;
    // event strobe for counter control
    logic wr_evt2;

    // driven from the top level ports
    modport top
    (
        output op, tos, rd_reg, wr_reg, wr_evt2
    );

    // every receiving block only listens
    modport blk
    (
        input op, tos, rd_reg, wr_reg, wr_evt2
    );

endinterface

// ==== ctrl_regs.sv ====
//////////////////////////////////////////////////////////////////////
// global control register written by SET_CTRL from tos[15:0]
// outputs follow the register one cycle after the write
// serial lines reach only the port picked by the select field
//////////////////////////////////////////////////////////////////////

module ctrl_regs import kiwi_pkg::*;
(
    input  logic   cpu_clk,
    input  logic   rx_orst,
    cpu_bus_if.blk bus,
    output logic   da_dale,
    output logic   da_daclk,
    output logic   da_dadat,
    output logic   gps_gscs,
    output logic   gps_gsclk,
    output logic   gps_gsdat,
    output logic   adc_stenl,
    output logic   adc_clken,
    output logic   ewp,
    output logic   cmd_ready,
    output logic   snd_intr
);

    logic [15:0] ctrl;
    logic [1:0]  ser_sel;
    // {data, clk, le/csn}
    logic [2:0]  ser_bits;
    logic [2:0]  ser_attn;
    logic [2:0]  ser_gps;

    // control register
    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
            ctrl <= '0;
        else if (bus.wr_reg && bus.op[OP_SET_CTRL])
            ctrl <= bus.tos[15:0];
    end

    //////////////////////////////////////////////////////////////////
    // serial port steering
    //////////////////////////////////////////////////////////////////

    assign ser_sel  = ctrl[CTRL_SER_LSB +: 2];
    assign ser_bits = {ctrl[CTRL_SER_DATA], ctrl[CTRL_SER_CLK], ctrl[CTRL_SER_LE_CSN]};

    always_comb
    begin
        ser_attn = 3'b000;
        ser_gps  = 3'b000;
        case (ser_sel)
            SER_ATTN: ser_attn = ser_bits;
            SER_GPS:  ser_gps  = ser_bits;
            // none and the unused code park both ports low
            default:  ;
        endcase
    end

    assign {da_dadat, da_daclk, da_dale}    = ser_attn;
    assign {gps_gsdat, gps_gsclk, gps_gscs} = ser_gps;

    // fixed controls
    // self-test enable is active low at the ADC
    assign adc_stenl = !ctrl[CTRL_STEN];
    // oscillator runs unless disabled
    assign adc_clken = !ctrl[CTRL_OSC_DIS];
    assign ewp       = ctrl[CTRL_EEPROM_WP];
    assign cmd_ready = ctrl[CTRL_CMD_READY];
    assign snd_intr  = ctrl[CTRL_SND_INTR];

    // attenuator and GPS front-end never see serial activity together
    assert property (@(posedge cpu_clk) disable iff (rx_orst)
        !((da_dale || da_daclk || da_dadat) && (gps_gscs || gps_gsclk || gps_gsdat)))
        else $error("attenuator and GPS serial ports both active");

endmodule

// ==== cycle_counters.sv ====
//////////////////////////////////////////////////////////////////////
// two CPU cycle counters for firmware profiling
// ctr0 free-runs, ctr1 counts only while enabled
// a clear hits both, counters wrap silently at 2^32
//////////////////////////////////////////////////////////////////////

module cycle_counters import kiwi_pkg::*;
(
    input  logic             cpu_clk,
    input  logic             rx_orst,
    cpu_bus_if.blk           bus,
    output logic [CTR_W-1:0] ctr0,
    output logic [CTR_W-1:0] ctr1
);

    logic ctr_ena;
    logic ctr_clr;
    logic ena_set;
    logic ena_clr;

    // event decode
    assign ctr_clr = bus.wr_evt2 && bus.op[OP_CPU_CTR_CLR];
    assign ena_set = bus.wr_evt2 && bus.op[OP_CPU_CTR_ENA];
    assign ena_clr = bus.wr_evt2 && bus.op[OP_CPU_CTR_DIS];

    //////////////////////////////////////////////////////////////////
    // counters
    //////////////////////////////////////////////////////////////////

    // clear edge loads zero, so N further edges read N
    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst || ctr_clr)
        begin
            ctr0 <= '0;
            ctr1 <= '0;
        end
        else
        begin
            ctr0 <= ctr0 + 1'b1;
            if (ctr_ena)
                ctr1 <= ctr1 + 1'b1;
        end
    end

    // gate for ctr1
    // takes effect on the edge after the strobe
    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
            ctr_ena <= 1'b0;
        else if (ena_set)
            ctr_ena <= 1'b1;
        else if (ena_clr)
            ctr_ena <= 1'b0;
    end

    // firmware must not ask for enable and disable at once
    assert property (@(posedge cpu_clk) disable iff (rx_orst)
        !(ena_set && ena_clr))
        else $error("CPU_CTR_ENA and CPU_CTR_DIS strobed together");

endmodule

// ==== event_latches.sv ====
//////////////////////////////////////////////////////////////////////
// sticky receiver overflow and host service-request capture
// rx_orst reloads the overflow flag rather than clearing it
// a request seen between two polls shows on ser_srq after the next one
//////////////////////////////////////////////////////////////////////

module event_latches import kiwi_pkg::*;
(
    input  logic   cpu_clk,
    input  logic   rx_orst,
    cpu_bus_if.blk bus,
    input  logic   rx_ovfl,
    input  logic   host_srq,
    output logic   rx_overflow,
    output logic   ser_srq
);

    logic srq_noted;
    logic srq_poll;

    // sticky overflow, host clears it through rx_orst
    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
            rx_overflow <= rx_ovfl;
        else
            rx_overflow <= rx_overflow | rx_ovfl;
    end

    //////////////////////////////////////////////////////////////////
    // service request capture
    //////////////////////////////////////////////////////////////////

    assign srq_poll = bus.rd_reg && bus.op[OP_GET_SRQ];

    // noted stage collects requests between polls
    // each poll hands the collected value to ser_srq
    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
        begin
            srq_noted <= 1'b0;
            ser_srq   <= 1'b0;
        end
        else if (srq_poll)
        begin
            srq_noted <= host_srq;
            ser_srq   <= srq_noted;
        end
        else
            srq_noted <= srq_noted | host_srq;
    end

    // once set, overflow stays set until the host resets it
    assert property (@(posedge cpu_clk) disable iff (rx_orst)
        rx_overflow |=> rx_overflow)
        else $error("overflow flag fell outside reset");

endmodule

// ==== read_mux.sv ====
//////////////////////////////////////////////////////////////////////
// CPU parallel read port is combinational in the strobe cycle
// counters are read one byte lane at a time by reg_no
// unmatched reads return host data
//////////////////////////////////////////////////////////////////////

module read_mux import kiwi_pkg::*;
(
    cpu_bus_if.blk           bus,
    input  logic [CTR_W-1:0] ctr0,
    input  logic [CTR_W-1:0] ctr1,
    input  logic [CTR_W-1:0] adc_count,
    input  logic             rx_overflow,
    input  logic [PAR_W-1:0] host_dout,
    output logic [PAR_W-1:0] par
);

    logic [1:0]       reg_no;
    logic [PAR_W-1:0] status;
    logic [3:0]       get_bits;

    assign reg_no = bus.op[REG_NO_LSB +: 2];

    // status word
    // ovfl, 3 zero bits, version, 4 zero bits, id
    assign status = {rx_overflow, 3'b000, FPGA_VER, 4'b0000, FPGA_ID};

    //////////////////////////////////////////////////////////////////
    // read select with fixed priority
    //////////////////////////////////////////////////////////////////

    always_comb
    begin
        par = host_dout;
        if (bus.rd_reg && bus.op[OP_GET_CPU_CTR])
            // ctr1 byte on top of the ctr0 byte
            par = {ctr1[8*reg_no +: 8], ctr0[8*reg_no +: 8]};
        else if (bus.rd_reg && bus.op[OP_GET_ADC_CTR] && reg_no == 2'd0)
            par = adc_count[15:0];
        else if (bus.rd_reg && bus.op[OP_GET_ADC_CTR] && reg_no == 2'd1)
            par = adc_count[31:16];
        // reg_no 2 and 3 fall through
        else if (bus.rd_reg && bus.op[OP_GET_STATUS])
            par = status;
    end

    // all GET functions that return through the read paths
    assign get_bits = {bus.op[OP_GET_STATUS], bus.op[OP_GET_CPU_CTR],
                       bus.op[OP_GET_ADC_CTR], bus.op[OP_GET_SRQ]};

    // the CPU reads one source per strobe
    always_comb
    begin
        assert final (!bus.rd_reg || $onehot0(get_bits))
            else $error("more than one GET op bit on a register read");
    end

endmodule

// ==== kiwi_core.sv ====
//////////////////////////////////////////////////////////////////////
// eCPU control and status block, all logic on cpu_clk
// rx_orst is the synchronous reset and the overflow reload
// par is combinational, every other output is registered state
//////////////////////////////////////////////////////////////////////

module kiwi_core import kiwi_pkg::*;
(
    input  logic             cpu_clk,
    input  logic             rx_orst,
    // CPU strobes and operands
    input  logic [OP_W-1:0]  op,
    input  logic [TOS_W-1:0] tos,
    input  logic             rd_reg,
    input  logic             wr_reg,
    input  logic             wr_evt2,
    // host and receiver side
    input  logic [PAR_W-1:0] host_dout,
    input  logic             host_srq,
    input  logic             rx_ovfl,
    input  logic [CTR_W-1:0] adc_count,
    // CPU read paths
    output logic [PAR_W-1:0] par,
    output logic             ser_srq,
    // attenuator serial
    output logic             da_dale,
    output logic             da_daclk,
    output logic             da_dadat,
    // GPS front-end serial
    output logic             gps_gscs,
    output logic             gps_gsclk,
    output logic             gps_gsdat,
    // board controls
    output logic             adc_stenl,
    output logic             adc_clken,
    output logic             ewp,
    output logic             cmd_ready,
    output logic             snd_intr
);

    logic [CTR_W-1:0] ctr0;
    logic [CTR_W-1:0] ctr1;
    logic             rx_overflow;

    //////////////////////////////////////////////////////////////////
    // CPU bus
    //////////////////////////////////////////////////////////////////

    cpu_bus_if bus ();

    assign bus.op      = op;
    assign bus.tos     = tos;
    assign bus.rd_reg  = rd_reg;
    assign bus.wr_reg  = wr_reg;
    assign bus.wr_evt2 = wr_evt2;

    //////////////////////////////////////////////////////////////////
    // blocks
    //////////////////////////////////////////////////////////////////

    ctrl_regs u_ctrl_regs
    (
        .cpu_clk   (cpu_clk),
        .rx_orst   (rx_orst),
        .bus       (bus),
        .da_dale   (da_dale),
        .da_daclk  (da_daclk),
        .da_dadat  (da_dadat),
        .gps_gscs  (gps_gscs),
        .gps_gsclk (gps_gsclk),
        .gps_gsdat (gps_gsdat),
        .adc_stenl (adc_stenl),
        .adc_clken (adc_clken),
        .ewp       (ewp),
        .cmd_ready (cmd_ready),
        .snd_intr  (snd_intr)
    );

    cycle_counters u_cycle_counters
    (
        .cpu_clk (cpu_clk),
        .rx_orst (rx_orst),
        .bus     (bus),
        .ctr0    (ctr0),
        .ctr1    (ctr1)
    );

    event_latches u_event_latches
    (
        .cpu_clk     (cpu_clk),
        .rx_orst     (rx_orst),
        .bus         (bus),
        .rx_ovfl     (rx_ovfl),
        .host_srq    (host_srq),
        .rx_overflow (rx_overflow),
        .ser_srq     (ser_srq)
    );

    // read port back to the CPU
    read_mux u_read_mux
    (
        .bus         (bus),
        .ctr0        (ctr0),
        .ctr1        (ctr1),
        .adc_count   (adc_count),
        .rx_overflow (rx_overflow),
        .host_dout   (host_dout),
        .par         (par)
    );

endmodule

// ==== tb_kiwi_core.sv ====
//////////////////////////////////////////////////////////////////////
// self-checking testbench for kiwi_core
// concurrent assertions compare DUT outputs with expected state
// inputs change 1 time unit after each rising edge of cpu_clk
//////////////////////////////////////////////////////////////////////

module tb_kiwi_core import kiwi_pkg::*;
();

    // DUT inputs
    logic             cpu_clk;
    logic             rx_orst;
    logic [OP_W-1:0]  op;
    logic [TOS_W-1:0] tos;
    logic             rd_reg;
    logic             wr_reg;
    logic             wr_evt2;
    logic [PAR_W-1:0] host_dout;
    logic             host_srq;
    logic             rx_ovfl;
    logic [CTR_W-1:0] adc_count;

    // DUT outputs
    logic [PAR_W-1:0] par;
    logic             ser_srq;
    logic             da_dale;
    logic             da_daclk;
    logic             da_dadat;
    logic             gps_gscs;
    logic             gps_gsclk;
    logic             gps_gsdat;
    logic             adc_stenl;
    logic             adc_clken;
    logic             ewp;
    logic             cmd_ready;
    logic             snd_intr;
    logic [10:0]      pins;

    // expected values and check enables
    logic             check_par;
    logic             check_pins;
    logic             check_srq;
    logic [PAR_W-1:0] exp_par;
    logic [10:0]      exp_pins;
    logic             exp_srq;
    // requests collected since the last poll
    logic             srq_seen;
    // edge counts since the last counter clear
    int               edge_cnt;
    int               ctr1_cnt;
    logic             ctr1_on;

    int seed;
    int errors;
    int timeouts;

    kiwi_core uut
    (
        .cpu_clk   (cpu_clk),
        .rx_orst   (rx_orst),
        .op        (op),
        .tos       (tos),
        .rd_reg    (rd_reg),
        .wr_reg    (wr_reg),
        .wr_evt2   (wr_evt2),
        .host_dout (host_dout),
        .host_srq  (host_srq),
        .rx_ovfl   (rx_ovfl),
        .adc_count (adc_count),
        .par       (par),
        .ser_srq   (ser_srq),
        .da_dale   (da_dale),
        .da_daclk  (da_daclk),
        .da_dadat  (da_dadat),
        .gps_gscs  (gps_gscs),
        .gps_gsclk (gps_gsclk),
        .gps_gsdat (gps_gsdat),
        .adc_stenl (adc_stenl),
        .adc_clken (adc_clken),
        .ewp       (ewp),
        .cmd_ready (cmd_ready),
        .snd_intr  (snd_intr)
    );

    // attenuator, GPS, then the fixed controls
    assign pins = {da_dadat, da_daclk, da_dale, gps_gsdat, gps_gsclk, gps_gscs,
                   adc_stenl, adc_clken, ewp, cmd_ready, snd_intr};

    // 8 unit period
    initial
    begin
        cpu_clk = 1'b0;
        forever #4 cpu_clk = ~cpu_clk;
    end

    //////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////

    par_ok: assert property (@(posedge cpu_clk) check_par |-> par == exp_par)
        else
        begin
            errors++;
            $display("error at time %0t: par is %h, expected %h",
                     $time, $sampled(par), $sampled(exp_par));
        end

    pins_ok: assert property (@(posedge cpu_clk) check_pins |-> pins == exp_pins)
        else
        begin
            errors++;
            $display("error at time %0t: control pins are %b, expected %b",
                     $time, $sampled(pins), $sampled(exp_pins));
        end

    srq_ok: assert property (@(posedge cpu_clk) check_srq |-> ser_srq == exp_srq)
        else
        begin
            errors++;
            $display("error at time %0t: ser_srq is %b, expected %b",
                     $time, $sampled(ser_srq), $sampled(exp_srq));
        end

    //////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////

    function automatic logic [OP_W-1:0] op_word(input op_bit_e fn, input logic [1:0] reg_no);
        logic [OP_W-1:0] w;
        w = '0;
        w[fn] = 1'b1;
        w[REG_NO_LSB +: 2] = reg_no;
        return w;
    endfunction

    // pin levels expected one cycle after a control write
    function automatic logic [10:0] pins_for(input logic [15:0] val);
        logic [1:0] sel;
        logic [2:0] ser;
        logic [2:0] attn;
        logic [2:0] gps;
        sel  = val[CTRL_SER_LSB +: 2];
        // {data, clk, le/csn}
        ser  = val[CTRL_SER_LE_CSN +: 3];
        attn = (sel == SER_ATTN) ? ser : 3'b000;
        gps  = (sel == SER_GPS) ? ser : 3'b000;
        return {attn, gps, !val[CTRL_STEN], !val[CTRL_OSC_DIS],
                val[CTRL_EEPROM_WP], val[CTRL_CMD_READY], val[CTRL_SND_INTR]};
    endfunction

    // version 3, id 1
    function automatic logic [15:0] status_word(input logic ovf);
        return {ovf, 3'b000, 4'd3, 4'b0000, 4'd1};
    endfunction

    // one edge, then update the expected state
    task automatic tick();
        logic poll;
        logic req;
        poll = rd_reg && op[OP_GET_SRQ];
        req  = host_srq;
        @(posedge cpu_clk);
        #1;
        edge_cnt++;
        if (ctr1_on)
            ctr1_cnt++;
        if (poll)
        begin
            exp_srq  = srq_seen;
            srq_seen = req;
        end
        else
            srq_seen = srq_seen | req;
        host_dout = PAR_W'($random(seed));
        adc_count = $random(seed);
    endtask

    task automatic write_ctrl(input logic [15:0] val);
        wr_reg = 1'b1;
        op     = op_word(OP_SET_CTRL, 2'd0);
        // upper half of tos is ignored
        tos    = {16'($random(seed)), val};
        tick();
        wr_reg   = 1'b0;
        op       = '0;
        exp_pins = pins_for(val);
    endtask

    task automatic pulse_event(input op_bit_e fn);
        wr_evt2 = 1'b1;
        op      = op_word(fn, 2'd0);
        tick();
        wr_evt2 = 1'b0;
        op      = '0;
    endtask

    task automatic read_check(input logic strobe, input logic [OP_W-1:0] op_val,
                              input logic [PAR_W-1:0] expected);
        rd_reg    = strobe;
        op        = op_val;
        exp_par   = expected;
        check_par = 1'b1;
        tick();
        rd_reg    = 1'b0;
        op        = '0;
        check_par = 1'b0;
    endtask

    task automatic wait_srq(input logic level, input int limit);
        int n;
        n = 0;
        while (ser_srq !== level && n < limit)
        begin
            tick();
            n++;
        end
        if (ser_srq !== level)
        begin
            timeouts++;
            $display("timeout: ser_srq did not go to %0b within %0d cycles", level, limit);
        end
    endtask

    //////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////

    initial
    begin : stimulus
        int          sel;
        int          bits;
        logic [15:0] val;
        seed       = 99;
        rx_orst    = 1'b1;
        op         = '0;
        tos        = '0;
        rd_reg     = 1'b0;
        wr_reg     = 1'b0;
        wr_evt2    = 1'b0;
        host_dout  = PAR_W'($random(seed));
        host_srq   = 1'b0;
        rx_ovfl    = 1'b0;
        adc_count  = $random(seed);
        check_par  = 1'b0;
        check_pins = 1'b0;
        check_srq  = 1'b0;
        exp_par    = '0;
        exp_pins   = '0;
        exp_srq    = 1'b0;
        srq_seen   = 1'b0;
        edge_cnt   = 0;
        ctr1_cnt   = 0;
        ctr1_on    = 1'b0;
        errors     = 0;
        timeouts   = 0;

        repeat (16) @(posedge cpu_clk);
        #1;
        rx_orst = 1'b0;

        // reset state
        exp_pins   = pins_for(16'h0000);
        check_pins = 1'b1;
        check_srq  = 1'b1;
        tick();
        tick();

        // serial steering, every select code and serial pattern
        for (sel = 0; sel < 4; sel++)
        begin
            for (bits = 0; bits < 8; bits++)
            begin
                // random fixed-control bits 9..5
                val = 16'($random(seed)) & 16'h03e0;
                val[CTRL_SER_LE_CSN +: 3] = bits[2:0];
                val[CTRL_SER_LSB +: 2]    = sel[1:0];
                write_ctrl(val);
            end
        end
        write_ctrl(16'h0000);
        tick();

        // counters, ctr1 gated by ENA and DIS
        pulse_event(OP_CPU_CTR_CLR);
        edge_cnt = 0;
        ctr1_cnt = 0;
        repeat (3) read_check(1'b1, op_word(OP_GET_CPU_CTR, 2'd0),
                              {ctr1_cnt[7:0], edge_cnt[7:0]});
        pulse_event(OP_CPU_CTR_ENA);
        ctr1_on = 1'b1;
        // long enough to wrap the low byte
        repeat (260) read_check(1'b1, op_word(OP_GET_CPU_CTR, 2'd0),
                                {ctr1_cnt[7:0], edge_cnt[7:0]});
        pulse_event(OP_CPU_CTR_DIS);
        ctr1_on = 1'b0;
        repeat (6) read_check(1'b1, op_word(OP_GET_CPU_CTR, 2'd0),
                              {ctr1_cnt[7:0], edge_cnt[7:0]});

        // read mux paths
        repeat (4)
        begin
            read_check(1'b0, '0, host_dout);
            read_check(1'b1, '0, host_dout);
            read_check(1'b1, op_word(OP_GET_ADC_CTR, 2'd0), adc_count[15:0]);
            read_check(1'b1, op_word(OP_GET_ADC_CTR, 2'd1), adc_count[31:16]);
            read_check(1'b1, op_word(OP_GET_ADC_CTR, 2'd2), host_dout);
            read_check(1'b1, op_word(OP_GET_ADC_CTR, 2'd3), host_dout);
        end

        // sticky overflow
        read_check(1'b1, op_word(OP_GET_STATUS, 2'd0), status_word(1'b0));
        rx_ovfl = 1'b1;
        tick();
        rx_ovfl = 1'b0;
        repeat (3)
        begin
            tick();
            read_check(1'b1, op_word(OP_GET_STATUS, 2'd0), status_word(1'b1));
        end

        // service request between two polls
        read_check(1'b1, op_word(OP_GET_SRQ, 2'd0), host_dout);
        host_srq = 1'b1;
        tick();
        host_srq = 1'b0;
        tick();
        read_check(1'b1, op_word(OP_GET_SRQ, 2'd0), host_dout);
        wait_srq(1'b1, 4);
        read_check(1'b1, op_word(OP_GET_SRQ, 2'd0), host_dout);
        read_check(1'b1, op_word(OP_GET_SRQ, 2'd0), host_dout);
        wait_srq(1'b0, 4);

        // let the last checks fire
        tick();
        tick();
        $display("run complete: %0d assertion errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

    // overall run limit
    initial
    begin : watchdog
        repeat (5000) @(posedge cpu_clk);
        $display("simulation ran past its cycle limit and was stopped");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== sim.f ====
kiwi_pkg.sv
cpu_bus_if.sv
ctrl_regs.sv
cycle_counters.sv
event_latches.sv
read_mux.sv
kiwi_core.sv
tb_kiwi_core.sv

// ==== Bender.yml ====
package:
  name: kiwi_core

sources:
  - kiwi_pkg.sv
  - cpu_bus_if.sv
  - ctrl_regs.sv
  - cycle_counters.sv
  - event_latches.sv
  - read_mux.sv
  - kiwi_core.sv
  - target: simulation
    files:
      - tb_kiwi_core.sv
